/* run_sim.sh */
#!/usr/bin/env bash
# Builds the SpaceWire transmitter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sim.f --top-module tb_spw_tx -o tb_spw_tx

out=$(./obj_dir/tb_spw_tx)
echo "$out"

if echo "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1

/* sim.f */
+incdir+sim
source/spw_tx_pkg.sv
source/tx_char_sequencer.sv
source/tx_char_serializer.sv
source/tx_credit_counter.sv
source/tx_fct_request_counter.sv
source/spw_tx_top.sv
sim/tb_spw_tx.sv

/* sim/tb_spw_tx_tasks.svh */
//----------------------------------------------------------
// Directed tests and compare tasks for tb_spw_tx
// Tasks start and end 2 ns after a rising clock edge
//----------------------------------------------------------
`ifndef TB_SPW_TX_TASKS_SVH
`define TB_SPW_TX_TASKS_SVH

task automatic check_kind(input string name, input spw_tx_pkg::char_kind_e exp,
	input spw_tx_pkg::char_kind_e act);
	if (exp !== act)
	begin
		errors++;
		$display("[FAIL] %s: expected %s, actual %s (%0d)", name, exp.name(), act.name(), act);
	end
endtask

task automatic check_char(input string name, input spw_tx_pkg::spw_char_u exp,
	input spw_tx_pkg::spw_char_u act);
	if (exp !== act)
	begin
		errors++;
		$display("[FAIL] %s: expected %03h, actual %03h", name, exp, act);
	end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
	if (exp !== act)
	begin
		errors++;
		$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
	end
endtask

task automatic report_test(input string name, input int start);
	tests_run++;
	if (errors == start)
	begin
		$display("Test %s: ok", name);
	end
	else
	begin
		$display("Test %s: %0d errors", name, errors - start);
	end
endtask

task automatic tick();
	@(posedge pclk_tx);
	#2;
endtask

task automatic pop_char(input string name, output rx_char_s c);
	int n;
	n = 0;
	c = '0;
	while (rx_q.size() == 0 && n < CHAR_WAIT)
	begin
		tick();
		n++;
	end
	if (rx_q.size() == 0)
	begin
		errors++;
		$display("%s: timed out waiting for a character from the link", name);
	end
	else
	begin
		c = rx_q.pop_front();
	end
endtask

// Skips a bounded number of idle NULLs
task automatic pop_non_null(input string name, output rx_char_s c);
	int n;
	n = 0;
	pop_char(name, c);
	while (c.kind == spw_tx_pkg::char_null && n < 8)
	begin
		pop_char(name, c);
		n++;
	end
endtask

task automatic wait_take(input string name);
	int n;
	n = 0;
	@(negedge pclk_tx);
	while (!host_take && n < CHAR_WAIT)
	begin
		@(negedge pclk_tx);
		n++;
	end
	if (!host_take)
	begin
		errors++;
		$display("%s: the host character was never taken", name);
	end
	tick();
endtask

task automatic pulse_got_fct();
	got_fct = 1'b1;
	tick();
	got_fct = 1'b0;
endtask

task automatic pulse_fct_request();
	fct_request = 1'b1;
	tick();
	fct_request = 1'b0;
	tick();
endtask

//----------------------------------------------------------
// Directed tests
//----------------------------------------------------------
task automatic after_reset_nulls();
	string name;
	rx_char_s c;
	name = "after reset";
	check_bit(name, 1'b0, tx_dout);
	check_bit(name, 1'b0, tx_sout);
	check_bit(name, 1'b0, host_take);
	check_bit(name, 1'b0, credit_error);
	link_run = 1'b1;
	repeat (6)
	begin
		pop_char(name, c);
		check_kind(name, spw_tx_pkg::char_null, c.kind);
	end
	check_bit({name, ": bit every clock"}, 1'b1, stall_cnt == 0);
endtask

task automatic fct_request_burst();
	string name;
	rx_char_s c;
	name = "FCT requests";
	link_connected = 1'b1;
	rx_q.delete();
	repeat (3) pulse_fct_request();
	pop_non_null(name, c);
	check_kind(name, spw_tx_pkg::char_fct, c.kind);
	repeat (2)
	begin
		pop_char(name, c);
		check_kind(name, spw_tx_pkg::char_fct, c.kind);
	end
	pop_char(name, c);
	check_kind(name, spw_tx_pkg::char_null, c.kind);
endtask

task automatic credited_data();
	string name;
	logic [7:0] bytes [8];
	spw_tx_pkg::spw_char_u exp_chr;
	rx_char_s c;
	logic took;
	int i;
	name = "data with credit";
	rx_q.delete();
	pulse_got_fct();
	for (i = 0; i < 8; i++)
	begin
		bytes[i] = 8'($urandom);
		host_in.valid = 1'b1;
		host_in.chr.data.flag = 1'b0;
		host_in.chr.data.data_byte = bytes[i];
		wait_take(name);
	end
	// Ninth byte finds no credit left
	host_in.chr.data.data_byte = 8'($urandom);
	took = 1'b0;
	repeat (30)
	begin
		@(negedge pclk_tx);
		took = took | host_take;
	end
	check_bit({name, ": ninth byte taken"}, 1'b0, took);
	tick();
	host_in = '0;
	for (i = 0; i < 8; i++)
	begin
		pop_non_null(name, c);
		exp_chr = '0;
		exp_chr.data.data_byte = bytes[i];
		check_kind(name, spw_tx_pkg::char_data, c.kind);
		check_char(name, exp_chr, c.chr);
	end
	repeat (2)
	begin
		pop_char(name, c);
		check_kind(name, spw_tx_pkg::char_null, c.kind);
	end
endtask

task automatic end_markers();
	string name;
	spw_tx_pkg::spw_char_u exp_chr;
	rx_char_s c;
	name = "end markers";
	rx_q.delete();
	pulse_got_fct();
	exp_chr = '0;
	exp_chr.ctrl.flag = 1'b1;
	host_in.valid = 1'b1;
	host_in.chr = exp_chr;
	wait_take(name);
	host_in.chr.ctrl.code = 2'd1;
	wait_take(name);
	host_in = '0;
	pop_non_null(name, c);
	check_kind(name, spw_tx_pkg::char_eop, c.kind);
	check_char(name, exp_chr, c.chr);
	exp_chr.ctrl.code = 2'd1;
	pop_non_null(name, c);
	check_kind(name, spw_tx_pkg::char_eep, c.kind);
	check_char(name, exp_chr, c.chr);
	// Parity of the following NULL depends on the EEP code
	pop_char(name, c);
	check_kind(name, spw_tx_pkg::char_null, c.kind);
endtask

task automatic credit_overflow();
	string name;
	int n;
	logic held;
	name = "credit error";
	check_bit(name, 1'b0, credit_error);
	repeat (8) pulse_got_fct();
	n = 0;
	@(negedge pclk_tx);
	while (!credit_error && n < 20)
	begin
		@(negedge pclk_tx);
		n++;
	end
	check_bit(name, 1'b1, credit_error);
	held = 1'b1;
	repeat (20)
	begin
		@(negedge pclk_tx);
		held = held & credit_error;
	end
	check_bit({name, ": sticky"}, 1'b1, held);
	tick();
endtask

`endif

/* sim/tb_spw_tx.sv */
//----------------------------------------------------------
// Testbench for the SpaceWire transmitter with a DS decoder
// The monitor assumes link_run stays high once it is raised
//----------------------------------------------------------
`timescale 1ns/100ps

module tb_spw_tx;

	localparam int CHAR_WAIT = 40;

	typedef struct packed
	{
		spw_tx_pkg::char_kind_e kind;
		spw_tx_pkg::spw_char_u chr;
	} rx_char_s;

	logic pclk_tx;
	logic enable_tx;
	logic link_run;
	logic link_connected;
	spw_tx_pkg::host_char_s host_in;
	logic got_fct;
	logic fct_request;
	logic host_take;
	logic tx_dout;
	logic tx_sout;
	logic credit_error;

	// Monitor state
	rx_char_s rx_q[$];
	logic [9:0] rx_bits = '0;
	int rx_cnt = 0;
	logic prev_x = 1'b0;
	logic prev_trail = 1'b0;
	logic esc_seen = 1'b0;
	logic toggle_seen = 1'b0;
	int stall_cnt = 0;

	int errors = 0;
	int tests_run = 0;
	int err_start;
	string cur_test = "reset";

	spw_tx_top dut_i
	(
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.link_run(link_run),
		.link_connected(link_connected),
		.host_in(host_in),
		.got_fct(got_fct),
		.fct_request(fct_request),
		.host_take(host_take),
		.tx_dout(tx_dout),
		.tx_sout(tx_sout),
		.credit_error(credit_error)
	);

	`include "tb_spw_tx_tasks.svh"

	initial
	begin
		pclk_tx = 1'b0;
		forever #10 pclk_tx = ~pclk_tx;
	end

	//----------------------------------------------------------
	// DS monitor takes one bit per change of dout xor sout
	//----------------------------------------------------------
	always @(negedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			rx_cnt = 0;
			prev_x = 1'b0;
			prev_trail = 1'b0;
			esc_seen = 1'b0;
			toggle_seen = 1'b0;
			stall_cnt = 0;
		end
		else
		begin
			if ((tx_dout ^ tx_sout) != prev_x)
			begin
				toggle_seen = 1'b1;
				rx_bits[rx_cnt] = tx_dout;
				rx_cnt++;
				// Flag bit decides between 4 and 10 bits
				if (rx_cnt == 10 || (rx_cnt == 4 && rx_bits[1]))
				begin
					decode_char();
					rx_cnt = 0;
				end
			end
			else if (toggle_seen)
			begin
				stall_cnt++;
			end
			prev_x = tx_dout ^ tx_sout;
		end
	end

	task automatic decode_char();
		logic exp_par;
		logic [1:0] code;
		rx_char_s c;
		exp_par = ~(prev_trail ^ rx_bits[1]);
		// Code as {second bit, first bit} after the flag
		code = {rx_bits[3], rx_bits[2]};
		c = '0;
		c.kind = spw_tx_pkg::char_null;
		check_bit({cur_test, ": parity"}, exp_par, rx_bits[0]);
		if (esc_seen)
		begin
			esc_seen = 1'b0;
			prev_trail = 1'b0;
			if (!rx_bits[1] || code != 2'b00)
			begin
				errors++;
				$display("Monitor: ESC was not followed by an FCT");
			end
			else
			begin
				rx_q.push_back(c);
			end
		end
		else if (!rx_bits[1])
		begin
			c.kind = spw_tx_pkg::char_data;
			c.chr.data.data_byte = rx_bits[9:2];
			prev_trail = ^rx_bits[9:2];
			rx_q.push_back(c);
		end
		else
		begin
			prev_trail = code[0] ^ code[1];
			c.chr.ctrl.flag = 1'b1;
			case (code)
				2'b00:
				begin
					c = '0;
					c.kind = spw_tx_pkg::char_fct;
					rx_q.push_back(c);
				end
				2'b10:
				begin
					c.kind = spw_tx_pkg::char_eop;
					c.chr.ctrl.code = 2'd0;
					rx_q.push_back(c);
				end
				2'b01:
				begin
					c.kind = spw_tx_pkg::char_eep;
					c.chr.ctrl.code = 2'd1;
					rx_q.push_back(c);
				end
				default:
				begin
					esc_seen = 1'b1;
				end
			endcase
		end
	endtask

	//----------------------------------------------------------
	// Test sequence
	//----------------------------------------------------------
	initial
	begin
		enable_tx = 1'b0;
		link_run = 1'b0;
		link_connected = 1'b0;
		host_in = '0;
		got_fct = 1'b0;
		fct_request = 1'b0;
		void'($urandom(89));
		repeat (8) @(posedge pclk_tx);
		#2;
		enable_tx = 1'b1;

		cur_test = "after reset";
		err_start = errors;
		after_reset_nulls();
		report_test(cur_test, err_start);
		cur_test = "FCT requests";
		err_start = errors;
		fct_request_burst();
		report_test(cur_test, err_start);
		cur_test = "data with credit";
		err_start = errors;
		credited_data();
		report_test(cur_test, err_start);
		cur_test = "end markers";
		err_start = errors;
		end_markers();
		report_test(cur_test, err_start);
		cur_test = "credit error";
		err_start = errors;
		credit_overflow();
		report_test(cur_test, err_start);

		$display("Tests run: %0d, errors: %0d", tests_run, errors);
		if (errors == 0)
		begin
			$display("Verification passed");
		end
		else
		begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

/* source/spw_tx_pkg.sv */
//----------------------------------------------------------
// Shared types and constants of the SpaceWire transmitter
// Control codes hold the bits after parity, sent LSB first
//----------------------------------------------------------

package spw_tx_pkg;

	//----------------------------------------------------------
	// Widths
	//----------------------------------------------------------
	localparam int CREDIT_W = 6;
	localparam int FCT_REQ_W = 3;
	localparam int BIT_CNT_W = 4;

	// Character lengths, parity and flag included
	localparam logic [BIT_CNT_W-1:0] NULL_LEN = 4'd8;
	localparam logic [BIT_CNT_W-1:0] FCT_LEN = 4'd4;
	localparam logic [BIT_CNT_W-1:0] DATA_LEN = 4'd10;
	localparam logic [BIT_CNT_W-1:0] EOP_LEN = 4'd4;

	// Bits that follow the parity bit, LSB first
	// NULL is ESC then FCT, its inner parity is always 0
	localparam logic [6:0] NULL_CODE = 7'b0010111;
	localparam logic [2:0] FCT_CODE = 3'b001;
	localparam logic [2:0] EOP_CODE = 3'b101;
	localparam logic [2:0] EEP_CODE = 3'b011;

	//----------------------------------------------------------
	// Flow control limits
	//----------------------------------------------------------
	localparam logic [CREDIT_W-1:0] CREDIT_PER_FCT = 6'd8;
	localparam logic [CREDIT_W-1:0] CREDIT_MAX = 6'd56;
	localparam logic [FCT_REQ_W-1:0] FCT_REQ_MAX = 3'd7;

	typedef enum logic [2:0]
	{
		char_null = 3'd0,
		char_fct = 3'd1,
		char_data = 3'd2,
		char_eop = 3'd3,
		char_eep = 3'd4
	} char_kind_e;

	// One 9-bit character word, seen as data or as control
	typedef union packed
	{
		struct packed
		{
			logic flag;
			logic [7:0] data_byte;
		} data;
		struct packed
		{
			logic flag;
			logic [5:0] unused;
			logic [1:0] code;
		} ctrl;
	} spw_char_u;

	typedef struct packed
	{
		logic valid;
		spw_char_u chr;
	} host_char_s;

endpackage

/* source/spw_tx_top.sv */
//----------------------------------------------------------
// SpaceWire character transmitter, one bit per pclk_tx
// host_in must stay stable from valid until host_take
//----------------------------------------------------------
`timescale 1ns/100ps

module spw_tx_top
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic link_run,
	input logic link_connected,
	input spw_tx_pkg::host_char_s host_in,
	input logic got_fct,
	input logic fct_request,
	output logic host_take,
	output logic tx_dout,
	output logic tx_sout,
	output logic credit_error
);

	logic char_done;
	spw_tx_pkg::char_kind_e next_kind;
	spw_tx_pkg::spw_char_u next_char;
	logic data_sent;
	logic fct_sent;
	logic credit_avail;
	logic fct_pending;

	tx_char_sequencer u_sequencer
	(
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.link_run(link_run),
		.link_connected(link_connected),
		.host_in(host_in),
		.char_done(char_done),
		.credit_avail(credit_avail),
		.fct_pending(fct_pending),
		.next_kind(next_kind),
		.next_char(next_char),
		.host_take(host_take),
		.data_sent(data_sent),
		.fct_sent(fct_sent)
	);

	tx_char_serializer u_serializer
	(
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.link_run(link_run),
		.next_kind(next_kind),
		.next_char(next_char),
		.char_done(char_done),
		.tx_dout(tx_dout),
		.tx_sout(tx_sout)
	);

	tx_credit_counter u_credit
	(
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.got_fct(got_fct),
		.data_sent(data_sent),
		.credit_avail(credit_avail),
		.credit_error(credit_error)
	);

	tx_fct_request_counter u_fct_req
	(
		.pclk_tx(pclk_tx),
		.enable_tx(enable_tx),
		.fct_request(fct_request),
		.fct_sent(fct_sent),
		.fct_pending(fct_pending)
	);

endmodule

/* source/tx_char_sequencer.sv */
//----------------------------------------------------------
// Picks the next character at each boundary, combinationally
// Control words with a code other than 1 are sent as EOP
//----------------------------------------------------------
`timescale 1ns/100ps

module tx_char_sequencer
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic link_run,
	input logic link_connected,
	input spw_tx_pkg::host_char_s host_in,
	input logic char_done,
	input logic credit_avail,
	input logic fct_pending,
	output spw_tx_pkg::char_kind_e next_kind,
	output spw_tx_pkg::spw_char_u next_char,
	output logic host_take,
	output logic data_sent,
	output logic fct_sent
);

	logic started;
	logic boundary;
	logic send_fct;
	logic send_host;

	// A boundary only counts while the serializer is shifting
	assign boundary = char_done && link_run;

	//----------------------------------------------------------
	// Choice rule
	//----------------------------------------------------------
	// FCTs have priority over host characters
	assign send_fct = started && link_connected && fct_pending;
	assign send_host = started && link_connected && !fct_pending
		&& host_in.valid && credit_avail;

	always_comb
	begin
		next_kind = spw_tx_pkg::char_null;
		next_char = '0;
		if (send_fct)
		begin
			next_kind = spw_tx_pkg::char_fct;
		end
		else if (send_host)
		begin
			next_char = host_in.chr;
			if (!host_in.chr.data.flag)
			begin
				next_kind = spw_tx_pkg::char_data;
			end
			else if (host_in.chr.ctrl.code == 2'd1)
			begin
				next_kind = spw_tx_pkg::char_eep;
			end
			else
			begin
				next_kind = spw_tx_pkg::char_eop;
			end
		end
	end

	//----------------------------------------------------------
	// Boundary pulses
	//----------------------------------------------------------
	assign host_take = boundary && send_host;
	// Data, EOP and EEP all use one credit
	assign data_sent = host_take;
	assign fct_sent = boundary && send_fct;

	// First character after reset is always a NULL
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			started <= 1'b0;
		end
		else if (boundary)
		begin
			started <= 1'b1;
		end
	end

	//----------------------------------------------------------
	// Checks
	//----------------------------------------------------------
	// Host word is consumed only while it is offered
	a_take_needs_valid : assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		host_take |-> host_in.valid
	);

	// One character per boundary
	a_one_kind_sent : assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		!(fct_sent && data_sent)
	);

endmodule

/* source/tx_char_serializer.sv */
//----------------------------------------------------------
// Serializes characters LSB first in data-strobe form
// Outputs and state hold while link_run is low
//----------------------------------------------------------
`timescale 1ns/100ps

module tx_char_serializer
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic link_run,
	input spw_tx_pkg::char_kind_e next_kind,
	input spw_tx_pkg::spw_char_u next_char,
	output logic char_done,
	output logic tx_dout,
	output logic tx_sout
);

	// Bits still to send after the one on tx_dout
	logic [spw_tx_pkg::BIT_CNT_W-1:0] bit_cnt;
	logic [spw_tx_pkg::DATA_LEN-1:0] shift_q;
	logic [spw_tx_pkg::DATA_LEN-1:0] load_pat;
	logic [spw_tx_pkg::BIT_CNT_W-1:0] load_len;
	logic load_trail;
	logic prev_par;
	logic par_bit;
	logic dout_next;

	assign char_done = (bit_cnt == '0);

	//----------------------------------------------------------
	// Pattern of the next character
	//----------------------------------------------------------
	// Parity covers previous trailing bits plus the new flag
	assign par_bit = ~(prev_par ^ (next_kind != spw_tx_pkg::char_data));

	always_comb
	begin
		case (next_kind)
			spw_tx_pkg::char_fct:
			begin
				load_pat = {6'd0, spw_tx_pkg::FCT_CODE, par_bit};
				load_len = spw_tx_pkg::FCT_LEN;
				load_trail = 1'b0;
			end
			spw_tx_pkg::char_data:
			begin
				load_pat = {next_char.data.data_byte, 1'b0, par_bit};
				load_len = spw_tx_pkg::DATA_LEN;
				load_trail = ^next_char.data.data_byte;
			end
			spw_tx_pkg::char_eop:
			begin
				load_pat = {6'd0, spw_tx_pkg::EOP_CODE, par_bit};
				load_len = spw_tx_pkg::EOP_LEN;
				load_trail = 1'b1;
			end
			spw_tx_pkg::char_eep:
			begin
				load_pat = {6'd0, spw_tx_pkg::EEP_CODE, par_bit};
				load_len = spw_tx_pkg::EOP_LEN;
				load_trail = 1'b1;
			end
			default:
			begin
				load_pat = {2'd0, spw_tx_pkg::NULL_CODE, par_bit};
				load_len = spw_tx_pkg::NULL_LEN;
				load_trail = 1'b0;
			end
		endcase
	end

	assign dout_next = char_done ? load_pat[0] : shift_q[0];

	//----------------------------------------------------------
	// Control and DS outputs
	//----------------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			bit_cnt <= '0;
			prev_par <= 1'b0;
			tx_dout <= 1'b0;
			tx_sout <= 1'b0;
		end
		else if (link_run)
		begin
			if (char_done)
			begin
				bit_cnt <= load_len - 4'd1;
				prev_par <= load_trail;
			end
			else
			begin
				bit_cnt <= bit_cnt - 4'd1;
			end
			tx_dout <= dout_next;
			// Strobe toggles whenever data repeats
			tx_sout <= (dout_next == tx_dout) ? ~tx_sout : tx_sout;
		end
	end

	always_ff @(posedge pclk_tx)
	begin
		if (link_run)
		begin
			shift_q <= char_done ? (load_pat >> 1) : (shift_q >> 1);
		end
	end

	// Exactly one DS line moves per bit
	a_ds_single_change : assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		link_run |=> !($changed(tx_dout) && $changed(tx_sout))
	);

endmodule

/* source/tx_credit_counter.sv */
//----------------------------------------------------------
// Transmit credit, 8 per received FCT, limit 56
// credit_error stays set until reset
//----------------------------------------------------------
`timescale 1ns/100ps

module tx_credit_counter
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic got_fct,
	input logic data_sent,
	output logic credit_avail,
	output logic credit_error
);

	logic [spw_tx_pkg::CREDIT_W-1:0] credit;
	logic [spw_tx_pkg::CREDIT_W:0] credit_sum;
	logic overflow;

	assign credit_sum = {1'b0, credit}
		+ (got_fct ? {1'b0, spw_tx_pkg::CREDIT_PER_FCT} : 7'd0);
	assign overflow = got_fct && (credit_sum > {1'b0, spw_tx_pkg::CREDIT_MAX});
	assign credit_avail = (credit != '0);

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			credit <= '0;
			credit_error <= 1'b0;
		end
		else
		begin
			// Saturate first, then take the sent character
			credit <= (overflow ? spw_tx_pkg::CREDIT_MAX
				: credit_sum[spw_tx_pkg::CREDIT_W-1:0]) - {5'd0, data_sent};
			if (overflow)
			begin
				credit_error <= 1'b1;
			end
		end
	end

	a_no_send_without_credit : assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		data_sent |-> (credit != '0)
	);

endmodule

/* source/tx_fct_request_counter.sv */
//----------------------------------------------------------
// FCTs owed to the far end, saturating at 7
//----------------------------------------------------------
`timescale 1ns/100ps

module tx_fct_request_counter
(
	input logic pclk_tx,
	input logic enable_tx,
	input logic fct_request,
	input logic fct_sent,
	output logic fct_pending
);

	logic [spw_tx_pkg::FCT_REQ_W-1:0] req_cnt;
	logic inc;

	// A full count still takes a request when one leaves
	assign inc = fct_request && ((req_cnt != spw_tx_pkg::FCT_REQ_MAX) || fct_sent);
	assign fct_pending = (req_cnt != '0);

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			req_cnt <= '0;
		end
		else
		begin
			req_cnt <= req_cnt + {2'd0, inc} - {2'd0, fct_sent};
		end
	end

	a_fct_sent_needs_request : assert property (
		@(posedge pclk_tx) disable iff (!enable_tx)
		fct_sent |-> (req_cnt != '0)
	);

endmodule
